//--- src/scpu_ctrl_pkg.sv
package scpu_ctrl_pkg;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int bus_data_w  = 32;
    localparam int bus_addr_w  = 2;
    localparam int sram_addr_w = 10;
    localparam int sram_data_w = 8;
    localparam int frame_w     = sram_addr_w + sram_data_w;  // 18 bits on the wire
    localparam int adc_w       = 10;
    localparam int cnt_w       = 5;                          // Holds 0 to frame_w
    localparam int test_mux_w  = 3;

    typedef logic [bus_data_w-1:0]  bus_word_t;
    typedef logic [bus_addr_w-1:0]  bus_addr_t;
    typedef logic [sram_addr_w-1:0] sram_addr_t;
    typedef logic [sram_data_w-1:0] sram_data_t;
    typedef logic [frame_w-1:0]     frame_t;       // {address, data}
    typedef logic [adc_w-1:0]       adc_t;
    typedef logic [1:0]             link_mode_t;   // {mod1, mod0}
    typedef logic [cnt_w-1:0]       bit_cnt_t;

    // --------------------------------------------------
    // Register map and bit positions
    // --------------------------------------------------
    localparam bus_addr_t reg_ctrl      = 2'd0;  // Write control, read status
    localparam bus_addr_t reg_sram_addr = 2'd1;
    localparam bus_addr_t reg_sram_data = 2'd2;
    localparam bus_addr_t reg_adc       = 2'd3;

    // Control word
    localparam int idx_ctrl_bgn  = 0;
    localparam int idx_load      = 1;
    localparam int idx_mod0      = 2;
    localparam int idx_mod1      = 3;
    localparam int idx_app_done  = 4;
    localparam int idx_cpu_bgn   = 5;
    localparam int idx_rst_n     = 6;
    localparam int idx_cpu_wait  = 7;
    localparam int idx_test_mux  = 8;   // Three bits wide

    // Status word
    localparam int idx_ctrl_rdy  = 0;
    localparam int idx_nxt_end   = 1;
    localparam int idx_nxt_cont  = 2;
    localparam int idx_app_start = 3;
    localparam int idx_link_busy = 4;

    // Serial link direction
    localparam link_mode_t mode_send = 2'b00;  // Host to chip
    localparam link_mode_t mode_recv = 2'b10;  // Chip to host

endpackage

//--- src/host_regs.sv
`timescale 1ns/1ns

module host_regs import scpu_ctrl_pkg::*;
(
    input  logic                  csi_clk,
    input  logic                  rsi_reset_n,

    input  bus_addr_t             avs_address,
    input  logic                  avs_write,
    input  bus_word_t             avs_writedata,
    output bus_word_t             avs_readdata,

    input  frame_t                frame,
    input  logic                  busy,

    input  logic                  ctrl_rdy,
    input  logic                  nxt_end,
    input  logic                  nxt_cont,
    input  logic                  app_start,

    output logic                  ctrl_bgn,
    output logic                  ctrl_mod0,
    output logic                  ctrl_mod1,
    output logic                  rst_n_out,
    output logic                  cpu_wait,
    output logic                  app_done,
    output logic                  cpu_bgn,
    output logic [test_mux_w-1:0] test_mux,
    output adc_t                  adc_value,

    output logic                  load_pulse,
    output link_mode_t            link_mode,
    output sram_addr_t            sram_addr,
    output sram_data_t            sram_data
);

    logic       ctrl_wr;
    logic       ctrl_wr_d;     // Control write seen last cycle
    logic       mod0_q;
    logic       mod1_q;
    bus_word_t  status_word;

    assign ctrl_wr = avs_write && (avs_address == reg_ctrl);

    // --------------------------------------------------
    // Control word
    // --------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            ctrl_bgn  <= 1'b0;
            mod0_q    <= 1'b0;
            mod1_q    <= 1'b0;
            rst_n_out <= 1'b0;    // Chip held in reset
            cpu_wait  <= 1'b0;
            app_done  <= 1'b0;
            test_mux  <= '0;
        end
        else if (ctrl_wr)
        begin
            ctrl_bgn  <= avs_writedata[idx_ctrl_bgn];
            mod0_q    <= avs_writedata[idx_mod0];
            mod1_q    <= avs_writedata[idx_mod1];
            rst_n_out <= avs_writedata[idx_rst_n];
            cpu_wait  <= avs_writedata[idx_cpu_wait];
            app_done  <= avs_writedata[idx_app_done];
            test_mux  <= avs_writedata[idx_test_mux +: test_mux_w];
        end
    end

    // Only the first write of a back-to-back run fires a pulse
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            ctrl_wr_d  <= 1'b0;
            cpu_bgn    <= 1'b0;
            load_pulse <= 1'b0;
        end
        else
        begin
            ctrl_wr_d  <= ctrl_wr;
            cpu_bgn    <= ctrl_wr && !ctrl_wr_d && avs_writedata[idx_cpu_bgn];
            load_pulse <= ctrl_wr && !ctrl_wr_d && avs_writedata[idx_load];
        end
    end

    assign ctrl_mod0 = mod0_q;
    assign ctrl_mod1 = mod1_q & mod0_q;   // Pin mod1 needs mod0 set
    assign link_mode = {mod1_q, mod0_q};  // Raw mode for the link

    // --------------------------------------------------
    // Payload registers
    // --------------------------------------------------
    always_ff @(posedge csi_clk)
    begin
        if (avs_write && (avs_address == reg_sram_addr))
            sram_addr <= avs_writedata[sram_addr_w-1:0];
        if (avs_write && (avs_address == reg_sram_data))
            sram_data <= avs_writedata[sram_data_w-1:0];
    end

    // ADC value sent to the chip
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            adc_value <= '0;
        else if (avs_write && (avs_address == reg_adc))
            adc_value <= avs_writedata[adc_w-1:0];
    end

    // --------------------------------------------------
    // Read side
    // --------------------------------------------------
    always_comb
    begin
        status_word                = '0;
        status_word[idx_ctrl_rdy]  = ctrl_rdy;
        status_word[idx_nxt_end]   = nxt_end;
        status_word[idx_nxt_cont]  = nxt_cont;
        status_word[idx_app_start] = app_start;
        status_word[idx_link_busy] = busy;
    end

    always_comb
    begin
        case (avs_address)
            reg_ctrl:      avs_readdata = status_word;
            reg_sram_addr: avs_readdata = {{(bus_data_w-sram_addr_w){1'b0}},
                                           frame[frame_w-1 -: sram_addr_w]};
            reg_sram_data: avs_readdata = {{(bus_data_w-sram_data_w){1'b0}},
                                           frame[sram_data_w-1:0]};
            default:       avs_readdata = {{(bus_data_w-adc_w){1'b0}}, adc_value};
        endcase
    end

endmodule

//--- src/serial_link.sv
`timescale 1ns/1ns

module serial_link import scpu_ctrl_pkg::*;
(
    input  logic        csi_clk,
    input  logic        rsi_reset_n,

    input  logic        load_pulse,
    input  link_mode_t  link_mode,
    input  sram_addr_t  sram_addr,
    input  sram_data_t  sram_data,

    input  logic        ctrl_so,
    output logic        ctrl_si,

    output frame_t      frame,
    output logic        busy
);

    bit_cnt_t  bit_cnt;     // Shifts still to go
    logic      is_send;
    logic      is_recv;

    assign is_send = (link_mode == mode_send);
    assign is_recv = (link_mode == mode_recv);

    // --------------------------------------------------
    // Bit counter
    // --------------------------------------------------
    // A send shows bit 0 before any shift, so it needs one shift less
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
            bit_cnt <= '0;
        else if (load_pulse && is_send)
            bit_cnt <= bit_cnt_t'(frame_w - 1);
        else if (load_pulse && is_recv)
            bit_cnt <= bit_cnt_t'(frame_w);
        else if (bit_cnt != '0)
            bit_cnt <= bit_cnt - 1'b1;
    end

    assign busy = (bit_cnt != '0);

    // --------------------------------------------------
    // Frame register
    // --------------------------------------------------
    // Shift right, LSB goes out on si and so comes in at the top
    always_ff @(posedge csi_clk)
    begin
        if (!rsi_reset_n)
        begin
            frame <= '0;
        end
        else if (load_pulse && is_send)
        begin
            frame <= {sram_addr, sram_data};
        end
        else if (load_pulse && is_recv)
        begin
            frame <= frame;    // First sample taken next cycle
        end
        else if (busy)
        begin
            frame <= {ctrl_so, frame[frame_w-1:1]};
        end
    end

    assign ctrl_si = frame[0];

endmodule

//--- src/scpu_io_ctrl.sv
`timescale 1ns/1ns

module scpu_io_ctrl import scpu_ctrl_pkg::*;
(
    input  logic                  csi_clk,
    input  logic                  rsi_reset_n,

    // Avalon-MM slave
    input  bus_addr_t             avs_address,
    input  logic                  avs_write,
    input  bus_word_t             avs_writedata,
    output bus_word_t             avs_readdata,

    // Chip outputs
    output logic                  ctrl_bgn,
    output logic                  ctrl_mod0,
    output logic                  ctrl_mod1,
    output logic                  ctrl_load,
    output logic                  ctrl_si,
    output logic                  cpu_bgn,
    output logic                  cpu_wait,
    output logic                  app_done,
    output logic                  rst_n_out,
    output logic [test_mux_w-1:0] test_mux,
    output adc_t                  adc_value,

    // Chip inputs
    input  logic                  ctrl_so,
    input  logic                  ctrl_rdy,
    input  logic                  nxt_end,
    input  logic                  nxt_cont,
    input  logic                  app_start
);

    // --------------------------------------------------
    // Register side to link side
    // --------------------------------------------------
    logic        load_pulse;
    link_mode_t  link_mode;
    sram_addr_t  sram_addr;
    sram_data_t  sram_data;
    frame_t      frame;
    logic        busy;

    assign ctrl_load = load_pulse;  // Chip sees the same pulse as the link

    host_regs host_regs_i (
        .csi_clk       (csi_clk),
        .rsi_reset_n   (rsi_reset_n),
        .avs_address   (avs_address),
        .avs_write     (avs_write),
        .avs_writedata (avs_writedata),
        .avs_readdata  (avs_readdata),
        .frame         (frame),
        .busy          (busy),
        .ctrl_rdy      (ctrl_rdy),
        .nxt_end       (nxt_end),
        .nxt_cont      (nxt_cont),
        .app_start     (app_start),
        .ctrl_bgn      (ctrl_bgn),
        .ctrl_mod0     (ctrl_mod0),
        .ctrl_mod1     (ctrl_mod1),
        .rst_n_out     (rst_n_out),
        .cpu_wait      (cpu_wait),
        .app_done      (app_done),
        .cpu_bgn       (cpu_bgn),
        .test_mux      (test_mux),
        .adc_value     (adc_value),
        .load_pulse    (load_pulse),
        .link_mode     (link_mode),
        .sram_addr     (sram_addr),
        .sram_data     (sram_data)
    );

    serial_link serial_link_i (
        .csi_clk     (csi_clk),
        .rsi_reset_n (rsi_reset_n),
        .load_pulse  (load_pulse),
        .link_mode   (link_mode),
        .sram_addr   (sram_addr),
        .sram_data   (sram_data),
        .ctrl_so     (ctrl_so),
        .ctrl_si     (ctrl_si),
        .frame       (frame),
        .busy        (busy)
    );

endmodule

//--- test/tb_table.svh
typedef enum logic [3:0]
{
    op_write, op_burst, op_read, op_status, op_pins,
    op_pulses, op_wait, op_send, op_recv
} op_t;

typedef struct packed
{
    op_t       op;
    bus_addr_t addr;
    bus_word_t wdata;      // Write data, status pins or wait cycles
    bus_word_t exp_val;    // Read data, pin image, {cpu_bgn, load} pulse counts or frame
} step_t;

step_t steps [$];

function automatic step_t make_step(input op_t op, input bus_addr_t addr,
                                    input bus_word_t wdata, input bus_word_t exp_val);
    return '{op, addr, wdata, exp_val};
endfunction

// Each row holds operation, register, write data and expected value
task automatic build_steps();
    steps.push_back(make_step(op_read,   reg_sram_addr, 32'h0,         32'h0));
    steps.push_back(make_step(op_read,   reg_sram_data, 32'h0,         32'h0));
    steps.push_back(make_step(op_read,   reg_adc,       32'h0,         32'h0));
    steps.push_back(make_step(op_pins,   reg_ctrl,      32'h0,         32'h0));
    steps.push_back(make_step(op_status, reg_ctrl,      32'h0,         32'h0));
    // Payload registers keep only their low bits
    steps.push_back(make_step(op_write,  reg_adc,       32'hABCD_E3A7, 32'h0));
    steps.push_back(make_step(op_read,   reg_adc,       32'h0,         32'h3A7));
    steps.push_back(make_step(op_write,  reg_sram_addr, 32'hFFFF_F6A5, 32'h0));
    steps.push_back(make_step(op_write,  reg_sram_data, 32'h0000_123C, 32'h0));
    steps.push_back(make_step(op_write,  reg_ctrl,      32'h5DD,       32'h0));
    steps.push_back(make_step(op_pins,   reg_ctrl,      32'h0,         32'h5DD));
    steps.push_back(make_step(op_write,  reg_ctrl,      32'h2C8,       32'h0));
    steps.push_back(make_step(op_pins,   reg_ctrl,      32'h0,         32'h2C0)); // Mod1 without mod0
    steps.push_back(make_step(op_write,  reg_ctrl,      32'h60,        32'h0));
    steps.push_back(make_step(op_pulses, reg_ctrl,      32'h0,         32'h10));
    steps.push_back(make_step(op_write,  reg_ctrl,      32'h42,        32'h0));
    steps.push_back(make_step(op_pulses, reg_ctrl,      32'h0,         32'h01));
    steps.push_back(make_step(op_burst,  reg_ctrl,      32'h62,        32'h0));
    steps.push_back(make_step(op_pulses, reg_ctrl,      32'h0,         32'h11));
    steps.push_back(make_step(op_wait,   reg_ctrl,      32'd20,        32'h0));
    steps.push_back(make_step(op_write,  reg_ctrl,      32'h42,        32'h0));
    steps.push_back(make_step(op_send,   reg_ctrl,      32'h0,  bus_word_t'({10'h2A5, 8'h3C})));
    steps.push_back(make_step(op_wait,   reg_ctrl,      32'd2,         32'h0));
    steps.push_back(make_step(op_write,  reg_ctrl,      32'h4A,        32'h0));
    steps.push_back(make_step(op_pins,   reg_ctrl,      32'h0,         32'h42));
    steps.push_back(make_step(op_status, reg_ctrl,      32'h5,         32'h15)); // Link busy
    steps.push_back(make_step(op_recv,   reg_ctrl,      32'h0,         32'h0));
    steps.push_back(make_step(op_status, reg_ctrl,      32'hA,         32'hA));
    steps.push_back(make_step(op_status, reg_ctrl,      32'hF,         32'hF));
    steps.push_back(make_step(op_status, reg_ctrl,      32'h0,         32'h0));
endtask

//--- test/tb_scpu_io_ctrl.sv
`timescale 1ns/1ns

module tb_scpu_io_ctrl import scpu_ctrl_pkg::*;
();

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;

    logic csi_clk, rsi_reset_n, avs_write, ctrl_so, ctrl_rdy, nxt_end, nxt_cont, app_start;
    bus_addr_t avs_address;
    bus_word_t avs_writedata, avs_readdata;
    logic ctrl_bgn, ctrl_mod0, ctrl_mod1, ctrl_load, ctrl_si, cpu_bgn, cpu_wait, app_done;
    logic rst_n_out;
    logic [test_mux_w-1:0] test_mux;
    adc_t adc_value;

    int     seed = 72716;
    int     cpu_bgn_cnt, load_cnt;
    int     so_idx;
    frame_t chip_frame;       // Frame the chip model sends back
    logic   steps_ready = 1'b0;

    `include "tb_table.svh"

    scpu_io_ctrl scpu_io_ctrl_i (.*);

    initial
    begin
        csi_clk = 1'b0;
        forever #(clk_period / 2) csi_clk = ~csi_clk;
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_word(input string name, input bus_word_t got, input bus_word_t want);
        if (got !== want)
            stop_run($sformatf("ERR at %0t ns %s got %h expected %h", $time, name, got, want));
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want)
            stop_run($sformatf("ERR at %0t ns %s got %b expected %b", $time, name, got, want));
    endtask

    task automatic check_frame(input string name, input frame_t got, input frame_t want);
        if (got !== want)
            stop_run($sformatf("ERR at %0t ns %s got %h expected %h", $time, name, got, want));
    endtask

    // --------------------------------------------------
    // Bus and pin helpers
    // --------------------------------------------------
    task automatic count_pulses();
        cpu_bgn_cnt = cpu_bgn_cnt + int'(cpu_bgn);
        load_cnt    = load_cnt + int'(ctrl_load);
    endtask

    // Write held for back-to-back beats, pulses counted after each edge
    task automatic write_reg(input bus_addr_t addr, input bus_word_t wdata, input int beats);
        cpu_bgn_cnt   = 0;
        load_cnt      = 0;
        avs_address   = addr;
        avs_writedata = wdata;
        avs_write     = 1'b1;
        repeat (beats)
        begin
            @(negedge csi_clk);
            count_pulses();
        end
        avs_write = 1'b0;
    endtask

    task automatic read_reg(input bus_addr_t addr, output bus_word_t rd);
        avs_address = addr;
        #(clk_period / 4);
        rd = avs_readdata;
        @(negedge csi_clk);
    endtask

    task automatic check_pins(input bus_word_t img);
        check_bit("ctrl_bgn",  ctrl_bgn,  img[idx_ctrl_bgn]);
        check_bit("ctrl_load", ctrl_load, img[idx_load]);
        check_bit("ctrl_mod0", ctrl_mod0, img[idx_mod0]);
        check_bit("ctrl_mod1", ctrl_mod1, img[idx_mod1]);
        check_bit("app_done",  app_done,  img[idx_app_done]);
        check_bit("cpu_bgn",   cpu_bgn,   img[idx_cpu_bgn]);
        check_bit("rst_n_out", rst_n_out, img[idx_rst_n]);
        check_bit("cpu_wait",  cpu_wait,  img[idx_cpu_wait]);
        check_word("test_mux", bus_word_t'(test_mux), bus_word_t'(img[idx_test_mux +: test_mux_w]));
        @(negedge csi_clk);
    endtask

    task automatic check_pulses(input bus_word_t counts);
        repeat (3)
        begin
            @(negedge csi_clk);
            count_pulses();
        end
        check_word("cpu_bgn pulses", bus_word_t'(cpu_bgn_cnt), {28'd0, counts[7:4]});
        check_word("ctrl_load pulses", bus_word_t'(load_cnt), {28'd0, counts[3:0]});
    endtask

    // Bit k of the frame shows on si two cycles plus k after the write edge
    task automatic check_send(input frame_t want);
        frame_t got;
        int     k;
        got = '0;
        for (k = 0; k < frame_w; k++)
        begin
            @(negedge csi_clk);
            got[k] = ctrl_si;
            check_bit("busy", busy_now(), k < frame_w - 1);   // Low once the last bit is out
        end
        check_frame("ctrl_si frame", got, want);
    endtask

    function automatic logic busy_now();
        return scpu_io_ctrl_i.busy;
    endfunction

    task automatic check_recv();
        bus_word_t rd_hi, rd_lo;
        int        n;
        n = 0;
        while (busy_now())
        begin
            @(negedge csi_clk);
            n++;
            if (n > frame_w + 2)
                stop_run("The link stayed busy after a receive");
        end
        read_reg(reg_sram_addr, rd_hi);
        read_reg(reg_sram_data, rd_lo);
        check_frame("received frame", {rd_hi[sram_addr_w-1:0], rd_lo[sram_data_w-1:0]}, chip_frame);
    endtask

    task automatic run_step(input step_t st);
        bus_word_t rd;
        case (st.op)
            op_write:  write_reg(st.addr, st.wdata, 1);
            op_burst:  write_reg(st.addr, st.wdata, 2);
            op_read:
            begin
                read_reg(st.addr, rd);
                check_word("avs_readdata", rd, st.exp_val);
                if (st.addr == reg_adc)
                    check_word("adc_value", bus_word_t'(adc_value), st.exp_val);
            end
            op_status:
            begin
                {app_start, nxt_cont, nxt_end, ctrl_rdy} = st.wdata[3:0];
                read_reg(reg_ctrl, rd);
                check_word("status word", rd, st.exp_val);
            end
            op_pins:   check_pins(st.exp_val);
            op_pulses: check_pulses(st.exp_val);
            op_wait:   repeat (st.wdata) @(negedge csi_clk);
            op_send:   check_send(frame_t'(st.exp_val));
            op_recv:   check_recv();
            default:   stop_run("Unknown operation in the step table");
        endcase
    endtask

    // --------------------------------------------------
    // Chip model that serves a new random frame after each load
    // --------------------------------------------------
    initial
    begin
        ctrl_so    = 1'b0;
        chip_frame = '0;
        so_idx     = frame_w;    // Idle
        forever
        begin
            @(negedge csi_clk);
            if (so_idx < frame_w)
            begin
                ctrl_so = chip_frame[so_idx];
                so_idx++;
            end
            if (ctrl_load)
            begin
                chip_frame = frame_t'($random(seed));
                so_idx     = 0;
            end
        end
    end

    initial
    begin
        wait (steps_ready);
        #(clk_period * (reset_cycles + 40 * steps.size()));
        stop_run("Watchdog timeout, the step table did not finish in time");
    end

    initial
    begin
        rsi_reset_n   = 1'b0;
        avs_address   = '0;
        avs_write     = 1'b0;
        avs_writedata = '0;
        {app_start, nxt_cont, nxt_end, ctrl_rdy} = 4'b0;
        build_steps();
        steps_ready = 1'b1;
        repeat (reset_cycles) @(negedge csi_clk);
        rsi_reset_n = 1'b1;
        foreach (steps[i])
            run_step(steps[i]);
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- all.f
+incdir+test
src/scpu_ctrl_pkg.sv
src/host_regs.sv
src/serial_link.sv
src/scpu_io_ctrl.sv
test/tb_scpu_io_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns \
    --top-module tb_scpu_io_ctrl -f all.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

# Pass only if the testbench printed its pass line
grep -q "^NO ERRORS$" sim.log
